//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ulpb_mediator
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- build.f
+incdir+include
source/ulpb_pkg.sv
source/ulpb_clk_if.sv
source/ulpb_ctrl_fsm.sv
source/ulpb_clk_gen.sv
source/ulpb_mediator.sv
testbench/ulpb_ctrl_checker.sv
testbench/tb_ulpb_mediator.sv

//--- include/ulpb_params.svh
`ifndef ULPB_PARAMS_SVH
`define ULPB_PARAMS_SVH

// cycles spent in wait for start before the bus clock opens
`define ULPB_START_CYCLES 6

// control state encoding, 16 states
`define ULPB_STATE_W 4

// end-of-message and acknowledge step encoding
`define ULPB_SEQ_W 3

`endif

//--- source/ulpb_clk_gen.sv
`timescale 1ns/1ps

module ulpb_clk_gen
(
	input  logic   CLK,
	input  logic   RESET,
	output logic   clk_out,
	ulpb_clk_if.gen clk
);

	logic clk_half_q;

	// half-rate phase, held at 0 whenever the bus clock is off
	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
			clk_half_q <= 1'b0;
		else if (!clk.clk_en)
			clk_half_q <= 1'b0;
		else if (clk.half_run)
			clk_half_q <= ~clk_half_q;
	end

	assign clk.clk_half = clk_half_q;

	// bus clock idles high
	always_comb
	begin
		if (!clk.clk_en)
			clk_out = 1'b1;
		else if (clk.half_speed)
			clk_out = clk_half_q;
		else
			clk_out = CLK;
	end

endmodule

//--- source/ulpb_clk_if.sv
`timescale 1ns/1ps

interface ulpb_clk_if;

	// gating and divider control from the state machine
	logic clk_en;
	logic half_speed;
	logic half_run;
	// registered half-rate phase back from the generator
	logic clk_half;

	modport ctrl
	(
		output clk_en,
		output half_speed,
		output half_run,
		input  clk_half
	);

	modport gen
	(
		input  clk_en,
		input  half_speed,
		input  half_run,
		output clk_half
	);

endinterface

//--- source/ulpb_ctrl_fsm.sv
`timescale 1ns/1ps
`include "ulpb_params.svh"

module ulpb_ctrl_fsm
(
	input  logic                  CLK,
	input  logic                  RESET,
	input  logic                  din,
	output logic                  dout,
	output ulpb_pkg::ctrl_state_t state,
	ulpb_clk_if.ctrl              clk
);

	localparam int cnt_w = $clog2(`ULPB_START_CYCLES + 1);
	localparam logic [cnt_w-1:0] start_load = cnt_w'(`ULPB_START_CYCLES - 1);

	ulpb_pkg::ctrl_state_t next_state;
	ulpb_pkg::msg_seq_t    seq;
	ulpb_pkg::msg_seq_t    next_seq;
	logic [cnt_w-1:0]      start_cnt;
	logic [cnt_w-1:0]      next_start_cnt;
	logic [3:0]            hist;
	logic                  out_of_phase;
	logic                  hold;
	logic                  hold_val;

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			state     <= ulpb_pkg::st_bus_idle;
			seq       <= ulpb_pkg::seq_none;
			start_cnt <= start_load;
		end
		else
		begin
			state     <= next_state;
			seq       <= next_seq;
			start_cnt <= next_start_cnt;
		end
	end

	// last four sampled ring bits, newest in bit 0
	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
			hist <= 4'b0000;
		else
			hist <= {hist[2:0], din};
	end

	// per-state gating, speed and output hold
	always_comb
	begin
		clk.clk_en     = 1'b1;
		clk.half_speed = 1'b0;
		hold           = 1'b1;
		hold_val       = 1'b1;
		case (state)
			ulpb_pkg::st_bus_idle, ulpb_pkg::st_wait_start:
				clk.clk_en = 1'b0;
			ulpb_pkg::st_drive1, ulpb_pkg::st_latch1,
			ulpb_pkg::st_drive2, ulpb_pkg::st_latch2:
				hold = 1'b0;
			ulpb_pkg::st_rst_s0_d, ulpb_pkg::st_rst_s0_l,
			ulpb_pkg::st_rst_s0_d1, ulpb_pkg::st_rst_s0_l1:
			begin
				clk.half_speed = 1'b1;
				hold_val       = 1'b0;
			end
			ulpb_pkg::st_rst_s1_d, ulpb_pkg::st_rst_s1_l,
			ulpb_pkg::st_rst_r_d, ulpb_pkg::st_rst_r_l:
				clk.half_speed = 1'b1;
			default:
			begin
			end
		endcase
	end

	// divider stops on the last half of the release latch
	assign clk.half_run = clk.half_speed &&
		!((state == ulpb_pkg::st_rst_r_l) && clk.clk_half);

	assign dout = hold ? hold_val : din;

	// a node out of step shows as a bit flip within one drive
	assign out_of_phase = ((state == ulpb_pkg::st_drive1) || (state == ulpb_pkg::st_drive2))
		&& (hist[1] ^ hist[0]);

	always_comb
	begin
		next_state     = state;
		next_seq       = seq;
		next_start_cnt = start_cnt;
		case (state)
			ulpb_pkg::st_bus_idle:
			begin
				next_start_cnt = start_load;
				next_seq       = ulpb_pkg::seq_none;
				if (!din)
					next_state = ulpb_pkg::st_wait_start;
			end
			ulpb_pkg::st_wait_start:
			begin
				if (start_cnt != '0)
					next_start_cnt = start_cnt - 1'b1;
				else
					next_state = ulpb_pkg::st_enable_clk;
			end
			ulpb_pkg::st_enable_clk:
				next_state = ulpb_pkg::st_arb_res;
			ulpb_pkg::st_arb_res:
				next_state = ulpb_pkg::st_drive1;
			ulpb_pkg::st_drive1:
				next_state = out_of_phase ? ulpb_pkg::st_rst_s0_d : ulpb_pkg::st_latch1;
			ulpb_pkg::st_drive2:
				next_state = out_of_phase ? ulpb_pkg::st_rst_s0_d : ulpb_pkg::st_latch2;
			ulpb_pkg::st_latch1:
			begin
				next_state = ulpb_pkg::st_drive2;
				case (seq)
					ulpb_pkg::seq_none:
					begin
					end
					// third end-of-message bit must be 1
					ulpb_pkg::seq_eom_2:
						if (hist[0])
							next_seq = ulpb_pkg::seq_eom_3;
						else
							next_state = ulpb_pkg::st_rst_s0_d;
					// first ack bit is 0
					ulpb_pkg::seq_eom_done:
						if (!hist[0])
							next_seq = ulpb_pkg::seq_ack_1;
						else
							next_state = ulpb_pkg::st_rst_s0_d;
					ulpb_pkg::seq_ack_2:
						if (hist[0])
							next_seq = ulpb_pkg::seq_ack_done;
						else
							next_state = ulpb_pkg::st_rst_s0_d;
					default:
						next_state = ulpb_pkg::st_rst_s0_d;
				endcase
			end
			ulpb_pkg::st_latch2:
			begin
				next_state = ulpb_pkg::st_drive1;
				case (seq)
					ulpb_pkg::seq_none:
						if ({hist[2], hist[0]} == 2'b01)
							next_seq = ulpb_pkg::seq_eom_2;
						else if ({hist[2], hist[0]} == 2'b10)
							next_state = ulpb_pkg::st_rst_s0_d;
					// 0110 ends the message, 0111 is an error
					ulpb_pkg::seq_eom_3:
						if (!hist[0])
							next_seq = ulpb_pkg::seq_eom_done;
						else
							next_state = ulpb_pkg::st_rst_s0_d;
					ulpb_pkg::seq_ack_1:
						if (hist[0])
							next_seq = ulpb_pkg::seq_ack_2;
						else
							next_state = ulpb_pkg::st_rst_s0_d;
					default:
						next_state = ulpb_pkg::st_rst_s0_d;
				endcase
			end
			// each reset state steps on the second half-rate cycle
			ulpb_pkg::st_rst_s0_d:
				if (clk.clk_half)
					next_state = ulpb_pkg::st_rst_s0_l;
			ulpb_pkg::st_rst_s0_l:
				if (clk.clk_half)
					next_state = (hist[2:0] == 3'b000) ? ulpb_pkg::st_rst_s1_d
						: ulpb_pkg::st_rst_s0_d;
			ulpb_pkg::st_rst_s1_d:
				if (clk.clk_half)
					next_state = ulpb_pkg::st_rst_s1_l;
			ulpb_pkg::st_rst_s1_l:
				if (clk.clk_half)
					next_state = (hist == 4'b0111) ? ulpb_pkg::st_rst_s0_d1
						: ulpb_pkg::st_rst_s0_d;
			ulpb_pkg::st_rst_s0_d1:
				if (clk.clk_half)
					next_state = ulpb_pkg::st_rst_s0_l1;
			ulpb_pkg::st_rst_s0_l1:
				if (clk.clk_half)
					next_state = (hist == 4'b1000) ? ulpb_pkg::st_rst_r_d
						: ulpb_pkg::st_rst_s0_d;
			ulpb_pkg::st_rst_r_d:
				if (clk.clk_half)
					next_state = ulpb_pkg::st_rst_r_l;
			ulpb_pkg::st_rst_r_l:
				if (clk.clk_half)
					next_state = ulpb_pkg::st_bus_idle;
			default:
				next_state = ulpb_pkg::st_bus_idle;
		endcase
	end

endmodule

//--- source/ulpb_mediator.sv
`timescale 1ns/1ps

module ulpb_mediator
(
	input  logic                  CLK,
	input  logic                  RESET,
	input  logic                  din,
	output logic                  dout,
	output logic                  clk_out,
	output ulpb_pkg::ctrl_state_t state_mon
);

	ulpb_clk_if clk_bus ();

	// protocol decisions
	ulpb_ctrl_fsm u_fsm
	(
		.CLK   (CLK),
		.RESET (RESET),
		.din   (din),
		.dout  (dout),
		.state (state_mon),
		.clk   (clk_bus.ctrl)
	);

	// divider and bus clock gating
	ulpb_clk_gen u_clk_gen
	(
		.CLK     (CLK),
		.RESET   (RESET),
		.clk_out (clk_out),
		.clk     (clk_bus.gen)
	);

endmodule

//--- source/ulpb_pkg.sv
`include "ulpb_params.svh"

package ulpb_pkg;

	// bus control states, encoding fixed for the monitor port
	typedef enum logic [`ULPB_STATE_W-1:0]
	{
		st_bus_idle   = 4'd0,
		st_wait_start = 4'd1,
		st_enable_clk = 4'd2,
		st_arb_res    = 4'd3,
		st_drive1     = 4'd4,
		st_latch1     = 4'd5,
		st_drive2     = 4'd6,
		st_latch2     = 4'd7,
		st_rst_s0_d   = 4'd8,
		st_rst_s0_l   = 4'd9,
		st_rst_s1_d   = 4'd10,
		st_rst_s1_l   = 4'd11,
		st_rst_s0_d1  = 4'd12,
		st_rst_s0_l1  = 4'd13,
		st_rst_r_d    = 4'd14,
		st_rst_r_l    = 4'd15
	} ctrl_state_t;

	// steps through the 0110 end of message and the acknowledge bits
	typedef enum logic [`ULPB_SEQ_W-1:0]
	{
		seq_none     = 3'd0,
		seq_eom_2    = 3'd1,
		seq_eom_3    = 3'd2,
		seq_eom_done = 3'd3,
		seq_ack_1    = 3'd4,
		seq_ack_2    = 3'd5,
		seq_ack_done = 3'd6
	} msg_seq_t;

endpackage

//--- testbench/tb_ulpb_mediator.sv
`timescale 1ns/1ps

module tb_ulpb_mediator;

	logic                  CLK;
	logic                  RESET;
	logic                  din;
	logic                  dout;
	logic                  clk_out;
	ulpb_pkg::ctrl_state_t state_mon;
	logic [31:0]           rng;
	int                    timeouts;

	ulpb_mediator u_dut
	(
		.CLK       (CLK),
		.RESET     (RESET),
		.din       (din),
		.dout      (dout),
		.clk_out   (clk_out),
		.state_mon (state_mon)
	);

	always #50 CLK = ~CLK;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	task automatic next_cycle();
		@(posedge CLK);
		#5;
	endtask

	// one bit over a drive and latch pair, flip breaks the pair
	task automatic send_bit(input logic b, input logic flip);
		din = b;
		next_cycle();
		din = b ^ flip;
		next_cycle();
	endtask

	task automatic run_txn(input int kind, input logic corrupt, input logic [1:0] sel);
		int n;
		int rounds;
		logic pending;
		ulpb_pkg::ctrl_state_t target;
		pending = corrupt;
		target  = (sel == 2'd0) ? ulpb_pkg::st_rst_s0_l
			: (sel == 2'd1) ? ulpb_pkg::st_rst_s1_l : ulpb_pkg::st_rst_s0_l1;
		// member pulls the line low, then the ring echoes the node
		din = 1'b0;
		next_cycle();
		din = dout;
		n = 0;
		while (state_mon != ulpb_pkg::st_drive1 && n < 20)
		begin
			next_cycle();
			din = dout;
			n++;
		end
		if (n >= 20)
		begin
			$display("timeout: the bus clock never opened after a start request");
			timeouts++;
			return;
		end
		rounds = 1 + rng[3:2];
		for (int i = 0; i < rounds; i++)
		begin
			rng = xorshift(rng);
			send_bit(rng[0], 1'b0);
			send_bit(rng[0], 1'b0);
		end
		case (kind)
			0:
			begin
				send_bit(1'b0, 1'b0);
				send_bit(1'b1, 1'b0);
				send_bit(1'b1, 1'b0);
				send_bit(1'b0, 1'b0);
				send_bit(1'b0, 1'b0);
				send_bit(1'b1, 1'b0);
				send_bit(1'b1, 1'b0);
				send_bit(1'b1, 1'b0);
			end
			1:
			begin
				send_bit(1'b0, 1'b0);
				send_bit(1'b1, 1'b0);
				send_bit(1'b1, 1'b0);
				send_bit(1'b1, 1'b0);
			end
			default:
				send_bit(rng[1], 1'b1);
		endcase
		din = dout;
		n = 0;
		while (state_mon != ulpb_pkg::st_bus_idle && n < 100)
		begin
			next_cycle();
			din = dout;
			if (pending && state_mon == target)
			begin
				// one wrong bit from the ring
				din     = ~dout;
				pending = 1'b0;
			end
			n++;
		end
		if (n >= 100)
		begin
			$display("timeout: the reset sequence never returned the bus to idle");
			timeouts++;
		end
	endtask

	initial
	begin
		int kind;
		CLK      = 1'b0;
		RESET    = 1'b0;
		din      = 1'b1;
		rng      = 32'h8f03;
		timeouts = 0;
		repeat (3) @(posedge CLK);
		#5;
		RESET = 1'b1;
		next_cycle();
		// first transactions break each reset check once
		for (int t = 0; t < 12; t++)
		begin
			rng  = xorshift(rng);
			kind = (t < 3) ? t : (t < 5) ? t - 2 : int'(rng[7:0] % 3);
			run_txn(kind, (kind != 0) && (rng[8] || t < 5),
				(t < 5) ? 2'(t % 3) : 2'(rng[5:4] % 3));
			next_cycle();
		end
		$display("errors: %0d assertion failures, %0d timeouts",
			u_dut.u_checker.fail_cnt, timeouts);
		if (u_dut.u_checker.fail_cnt == 0 && timeouts == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- testbench/ulpb_ctrl_checker.sv
`timescale 1ns/1ps
`include "ulpb_params.svh"

module ulpb_ctrl_checker
(
	input logic                  CLK,
	input logic                  RESET,
	input logic                  din,
	input logic                  dout,
	input logic                  clk_out,
	input ulpb_pkg::ctrl_state_t state_mon
);

	int unsigned fail_cnt = 0;
	logic [3:0]  din_hist;
	logic [5:0]  bit_hist;
	logic        clk_mid;
	logic        in_rst;
	logic        in_data;
	logic        rst_zero;

	assign in_rst   = (state_mon >= ulpb_pkg::st_rst_s0_d);
	assign in_data  = (state_mon inside {ulpb_pkg::st_drive1, ulpb_pkg::st_latch1,
		ulpb_pkg::st_drive2, ulpb_pkg::st_latch2});
	assign rst_zero = (state_mon inside {ulpb_pkg::st_rst_s0_d, ulpb_pkg::st_rst_s0_l,
		ulpb_pkg::st_rst_s0_d1, ulpb_pkg::st_rst_s0_l1});

	// ring bits at each edge, and the bit carried by each latch
	always_ff @(posedge CLK)
	begin
		din_hist <= {din_hist[2:0], din};
		if (state_mon == ulpb_pkg::st_latch1 || state_mon == ulpb_pkg::st_latch2)
			bit_hist <= {bit_hist[4:0], din};
	end

	// bus clock seen in the middle of the cycle
	always_ff @(negedge CLK)
		clk_mid <= clk_out;

	a_idle_high: assert property (@(posedge CLK)
		(state_mon == ulpb_pkg::st_bus_idle || state_mon == ulpb_pkg::st_wait_start)
		|-> (clk_out && dout))
	else
	begin
		fail_cnt++;
		$error("Fail %0t: bus clock or data not parked high", $time);
	end

	a_start: assert property (@(posedge CLK) disable iff (!RESET)
		(state_mon == ulpb_pkg::st_bus_idle && !din)
		|-> ##(`ULPB_START_CYCLES + 1) (state_mon == ulpb_pkg::st_enable_clk)
		##1 (state_mon == ulpb_pkg::st_arb_res) ##1 (state_mon == ulpb_pkg::st_drive1))
	else
	begin
		fail_cnt++;
		$error("Fail %0t: start request did not open the bus on time", $time);
	end

	a_dout: assert property (@(posedge CLK) disable iff (!RESET)
		dout == (in_data ? din : !rst_zero))
	else
	begin
		fail_cnt++;
		$error("Fail %0t: dout wrong for the state", $time);
	end

	a_phase: assert property (@(posedge CLK) disable iff (!RESET)
		((state_mon == ulpb_pkg::st_drive1 || state_mon == ulpb_pkg::st_drive2)
		&& (din_hist[1] != din_hist[0])) |=> (state_mon == ulpb_pkg::st_rst_s0_d))
	else
	begin
		fail_cnt++;
		$error("Fail %0t: out-of-phase drive did not start the reset sequence", $time);
	end

	a_rst_hold: assert property (@(posedge CLK) disable iff (!RESET)
		(in_rst && $changed(state_mon)) |=> $stable(state_mon) ##1 $changed(state_mon))
	else
	begin
		fail_cnt++;
		$error("Fail %0t: reset state did not last two cycles", $time);
	end

	a_rst_clk: assert property (@(posedge CLK) disable iff (!RESET)
		in_rst |-> (clk_out == clk_mid))
	else
	begin
		fail_cnt++;
		$error("Fail %0t: half-rate bus clock changed within a cycle", $time);
	end

	a_chk_zero: assert property (@(posedge CLK) disable iff (!RESET)
		(state_mon == ulpb_pkg::st_rst_s0_l && $stable(state_mon))
		|=> state_mon == (($past(din_hist[2:0]) == 3'b000) ? ulpb_pkg::st_rst_s1_d
		: ulpb_pkg::st_rst_s0_d))
	else
	begin
		fail_cnt++;
		$error("Fail %0t: wrong step after reset zero latch", $time);
	end

	a_chk_one: assert property (@(posedge CLK) disable iff (!RESET)
		(state_mon == ulpb_pkg::st_rst_s1_l && $stable(state_mon))
		|=> state_mon == (($past(din_hist) == 4'b0111) ? ulpb_pkg::st_rst_s0_d1
		: ulpb_pkg::st_rst_s0_d))
	else
	begin
		fail_cnt++;
		$error("Fail %0t: wrong step after reset one latch", $time);
	end

	a_chk_zero2: assert property (@(posedge CLK) disable iff (!RESET)
		(state_mon == ulpb_pkg::st_rst_s0_l1 && $stable(state_mon))
		|=> state_mon == (($past(din_hist) == 4'b1000) ? ulpb_pkg::st_rst_r_d
		: ulpb_pkg::st_rst_s0_d))
	else
	begin
		fail_cnt++;
		$error("Fail %0t: wrong step after second reset zero latch", $time);
	end

	a_release: assert property (@(posedge CLK) disable iff (!RESET)
		(state_mon == ulpb_pkg::st_rst_r_l && $stable(state_mon))
		|=> (state_mon == ulpb_pkg::st_bus_idle))
	else
	begin
		fail_cnt++;
		$error("Fail %0t: release latch did not return to idle", $time);
	end

	// 0110 then ack 011, ending on latch 1
	a_eom_ack: assert property (@(posedge CLK) disable iff (!RESET)
		(state_mon == ulpb_pkg::st_latch1 && {bit_hist, din} == 7'b0110011)
		|-> ##3 (state_mon == ulpb_pkg::st_rst_s0_d) ##4 (state_mon == ulpb_pkg::st_rst_s1_d)
		##4 (state_mon == ulpb_pkg::st_rst_s0_d1) ##4 (state_mon == ulpb_pkg::st_rst_r_d)
		##4 (state_mon == ulpb_pkg::st_bus_idle))
	else
	begin
		fail_cnt++;
		$error("Fail %0t: accepted message did not run a clean reset sequence", $time);
	end

endmodule

bind ulpb_mediator ulpb_ctrl_checker u_checker (.*);
